// File: segre_cfg.svh
`ifndef SEGRE_CFG_SVH
`define SEGRE_CFG_SVH

// Datapath widths
`define WORD_SIZE 32
`define ADDR_SIZE 32

// Register file index width
`define REG_SIZE 5

// Slots in the memory stage input buffer, valid range 1 to 8
`define EX_CREDITS 2

// Sequential PC increment
`define PC_STEP 4

`endif

// File: segre_pkg.sv
`default_nettype none

`include "segre_cfg.svh"

package segre_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [`ADDR_SIZE-1:0] addr_t;
    typedef logic [`REG_SIZE-1:0]  reg_idx_t;

    // Holds 0 to EX_CREDITS inclusive
    typedef logic [$clog2(`EX_CREDITS+1)-1:0] credit_cnt_t;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        // Conditional branches
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        // Unconditional jumps
        ALU_JAL,
        ALU_JALR
    } alu_opcode_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_data_type_e;

endpackage : segre_pkg

`default_nettype wire

// File: segre_alu.sv
`timescale 1ns/10ps
`default_nettype none

module segre_alu (
    input  segre_pkg::alu_opcode_e alu_opcode_i,
    input  segre_pkg::word_t       alu_src_a_i,
    input  segre_pkg::word_t       alu_src_b_i,
    output segre_pkg::word_t       alu_res_o
);

    import segre_pkg::*;

    logic [4:0] shamt;
    word_t      sum;

    assign shamt = alu_src_b_i[4:0];
    assign sum   = alu_src_a_i + alu_src_b_i;

    always_comb begin
        unique case (alu_opcode_i)
            ALU_ADD: begin
                alu_res_o = sum;
            end
            ALU_SUB: begin
                alu_res_o = alu_src_a_i - alu_src_b_i;
            end
            ALU_AND: begin
                alu_res_o = alu_src_a_i & alu_src_b_i;
            end
            ALU_OR: begin
                alu_res_o = alu_src_a_i | alu_src_b_i;
            end
            ALU_XOR: begin
                alu_res_o = alu_src_a_i ^ alu_src_b_i;
            end
            ALU_SLL: begin
                alu_res_o = alu_src_a_i << shamt;
            end
            ALU_SRL: begin
                alu_res_o = alu_src_a_i >> shamt;
            end
            ALU_SRA: begin
                alu_res_o = word_t'($signed(alu_src_a_i) >>> shamt);
            end
            ALU_SLT: begin
                alu_res_o = word_t'($signed(alu_src_a_i) < $signed(alu_src_b_i));
            end
            ALU_SLTU: begin
                alu_res_o = word_t'(alu_src_a_i < alu_src_b_i);
            end
            // Branch and JAL target is base plus offset
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_JAL: begin
                alu_res_o = sum;
            end
            // JALR target has bit 0 forced low
            ALU_JALR: begin
                alu_res_o = {sum[$bits(word_t)-1:1], 1'b0};
            end
            default: begin
                alu_res_o = '0;
            end
        endcase
    end

endmodule : segre_alu

`default_nettype wire

// File: segre_tkbr.sv
`timescale 1ns/10ps
`default_nettype none

module segre_tkbr (
    input  segre_pkg::alu_opcode_e alu_opcode_i,
    input  segre_pkg::word_t       br_src_a_i,
    input  segre_pkg::word_t       br_src_b_i,
    output logic                   tkbr_o
);

    import segre_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (br_src_a_i == br_src_b_i);
    assign lt_s = ($signed(br_src_a_i) < $signed(br_src_b_i));
    assign lt_u = (br_src_a_i < br_src_b_i);

    always_comb begin
        unique case (alu_opcode_i)
            ALU_BEQ:  tkbr_o = eq;
            ALU_BNE:  tkbr_o = !eq;
            ALU_BLT:  tkbr_o = lt_s;
            ALU_BGE:  tkbr_o = !lt_s;
            ALU_BLTU: tkbr_o = lt_u;
            ALU_BGEU: tkbr_o = !lt_u;
            // Jumps always redirect
            ALU_JAL, ALU_JALR: begin
                tkbr_o = 1'b1;
            end
            default: begin
                tkbr_o = 1'b0;
            end
        endcase
    end

endmodule : segre_tkbr

`default_nettype wire

// File: segre_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "segre_cfg.svh"

module segre_ex_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        valid_id_i,
    input  logic                        inject_nops_i,
    input  logic                        send_i,
    // ID/EX instruction
    input  segre_pkg::alu_opcode_e      alu_opcode_i,
    input  segre_pkg::word_t            alu_src_a_i,
    input  segre_pkg::word_t            alu_src_b_i,
    input  segre_pkg::word_t            br_src_a_i,
    input  segre_pkg::word_t            br_src_b_i,
    input  segre_pkg::word_t            rf_st_data_i,
    input  logic                        rf_we_i,
    input  segre_pkg::reg_idx_t         rf_waddr_i,
    input  segre_pkg::memop_data_type_e memop_type_i,
    input  logic                        memop_rd_i,
    input  logic                        memop_wr_i,
    input  logic                        memop_sign_ext_i,
    input  segre_pkg::addr_t            pc_i,
    // EX/MEM and redirect
    output logic                        held_o,
    output logic                        valid_ex_o,
    output segre_pkg::word_t            alu_res_o,
    output logic                        rf_we_o,
    output segre_pkg::reg_idx_t         rf_waddr_o,
    output segre_pkg::word_t            rf_st_data_o,
    output segre_pkg::memop_data_type_e memop_type_o,
    output logic                        memop_rd_o,
    output logic                        memop_wr_o,
    output logic                        memop_sign_ext_o,
    output logic                        tkbr_o,
    output segre_pkg::addr_t            new_pc_o,
    output segre_pkg::addr_t            seq_new_pc_o
);

    import segre_pkg::*;

    logic             load;
    logic             valid_q;
    logic             rf_we_q;
    logic             memop_rd_q;
    logic             memop_wr_q;
    alu_opcode_e      alu_opcode_q;
    word_t            alu_src_a_q;
    word_t            alu_src_b_q;
    word_t            br_src_a_q;
    word_t            br_src_b_q;
    word_t            rf_st_data_q;
    reg_idx_t         rf_waddr_q;
    memop_data_type_e memop_type_q;
    logic             memop_sign_ext_q;
    addr_t            seq_pc_q;
    word_t            alu_res;
    logic             tkbr;
    logic             is_jump;

    // Take a new item when empty or when the current one leaves
    assign load = !valid_q || send_i;

    always_ff @(posedge clk_i) begin
        if (rst_i || inject_nops_i) begin
            valid_q    <= 1'b0;
            rf_we_q    <= 1'b0;
            memop_rd_q <= 1'b0;
            memop_wr_q <= 1'b0;
        end else if (load) begin
            valid_q    <= valid_id_i;
            rf_we_q    <= rf_we_i;
            memop_rd_q <= memop_rd_i;
            memop_wr_q <= memop_wr_i;
        end
    end

    // Payload fields
    always_ff @(posedge clk_i) begin
        if (load) begin
            alu_opcode_q     <= alu_opcode_i;
            alu_src_a_q      <= alu_src_a_i;
            alu_src_b_q      <= alu_src_b_i;
            br_src_a_q       <= br_src_a_i;
            br_src_b_q       <= br_src_b_i;
            rf_st_data_q     <= rf_st_data_i;
            rf_waddr_q       <= rf_waddr_i;
            memop_type_q     <= memop_type_i;
            memop_sign_ext_q <= memop_sign_ext_i;
            seq_pc_q         <= pc_i + addr_t'(`PC_STEP);
        end
    end

    segre_alu i_segre_alu (
        .alu_opcode_i (alu_opcode_q),
        .alu_src_a_i  (alu_src_a_q),
        .alu_src_b_i  (alu_src_b_q),
        .alu_res_o    (alu_res)
    );

    segre_tkbr i_segre_tkbr (
        .alu_opcode_i (alu_opcode_q),
        .br_src_a_i   (br_src_a_q),
        .br_src_b_i   (br_src_b_q),
        .tkbr_o       (tkbr)
    );

    assign is_jump = (alu_opcode_q == ALU_JAL) || (alu_opcode_q == ALU_JALR);

    assign held_o     = valid_q;
    assign valid_ex_o = valid_q && send_i;
    assign tkbr_o     = tkbr && valid_ex_o;

    // Jumps write back the link address
    assign alu_res_o    = is_jump ? word_t'(seq_pc_q) : alu_res;
    assign new_pc_o     = addr_t'(alu_res);
    assign seq_new_pc_o = seq_pc_q;

    assign rf_we_o          = rf_we_q && valid_ex_o;
    assign memop_rd_o       = memop_rd_q && valid_ex_o;
    assign memop_wr_o       = memop_wr_q && valid_ex_o;
    assign rf_waddr_o       = rf_waddr_q;
    assign rf_st_data_o     = rf_st_data_q;
    assign memop_type_o     = memop_type_q;
    assign memop_sign_ext_o = memop_sign_ext_q;

    // A stalled item stays intact until a credit lets it go
    held_item_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (valid_q && !send_i && !inject_nops_i) |=>
            (valid_q && $stable({alu_opcode_q, alu_src_a_q, alu_src_b_q, br_src_a_q,
                                 br_src_b_q, rf_st_data_q, rf_waddr_q, seq_pc_q}))
    );

endmodule : segre_ex_stage

`default_nettype wire

// File: segre_ex_credit.sv
`timescale 1ns/10ps
`default_nettype none

`include "segre_cfg.svh"

module segre_ex_credit (
    input  logic clk_i,
    input  logic rst_i,
    input  logic item_held_i,
    input  logic credit_return_i,
    output logic send_o,
    output logic stall_o
);

    import segre_pkg::*;

    localparam credit_cnt_t MaxCredits = credit_cnt_t'(`EX_CREDITS);

    credit_cnt_t cnt_q;
    credit_cnt_t cnt_d;
    logic        has_credit;

    assign has_credit = (cnt_q != '0);
    assign send_o     = item_held_i && has_credit;
    assign stall_o    = item_held_i && !has_credit;

    // Return and send together cancel out
    always_comb begin
        cnt_d = cnt_q;
        if (send_o && !credit_return_i) begin
            cnt_d = cnt_q - 1'b1;
        end else if (credit_return_i && !send_o) begin
            cnt_d = cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= MaxCredits;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    credit_cnt_bounded: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cnt_q <= MaxCredits
    );

    // Memory stage frees only slots that were filled
    no_return_when_full: assert property (
        @(posedge clk_i) disable iff (rst_i)
        credit_return_i |-> (cnt_q != MaxCredits)
    );

endmodule : segre_ex_credit

`default_nettype wire

// File: segre_ex_top.sv
`timescale 1ns/10ps
`default_nettype none

module segre_ex_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        valid_id_i,
    input  logic                        inject_nops_i,
    input  logic                        credit_return_i,
    output logic                        stall_o,
    // From decode
    input  segre_pkg::alu_opcode_e      alu_opcode_i,
    input  segre_pkg::word_t            alu_src_a_i,
    input  segre_pkg::word_t            alu_src_b_i,
    input  segre_pkg::word_t            br_src_a_i,
    input  segre_pkg::word_t            br_src_b_i,
    input  segre_pkg::word_t            rf_st_data_i,
    input  logic                        rf_we_i,
    input  segre_pkg::reg_idx_t         rf_waddr_i,
    input  segre_pkg::memop_data_type_e memop_type_i,
    input  logic                        memop_rd_i,
    input  logic                        memop_wr_i,
    input  logic                        memop_sign_ext_i,
    input  segre_pkg::addr_t            pc_i,
    // To memory stage
    output logic                        valid_ex_o,
    output segre_pkg::word_t            alu_res_o,
    output logic                        rf_we_o,
    output segre_pkg::reg_idx_t         rf_waddr_o,
    output segre_pkg::word_t            rf_st_data_o,
    output segre_pkg::memop_data_type_e memop_type_o,
    output logic                        memop_rd_o,
    output logic                        memop_wr_o,
    output logic                        memop_sign_ext_o,
    // To fetch
    output logic                        tkbr_o,
    output segre_pkg::addr_t            new_pc_o,
    output segre_pkg::addr_t            seq_new_pc_o
);

    logic held;
    logic send;

    segre_ex_stage i_segre_ex_stage (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .valid_id_i       (valid_id_i),
        .inject_nops_i    (inject_nops_i),
        .send_i           (send),
        .alu_opcode_i     (alu_opcode_i),
        .alu_src_a_i      (alu_src_a_i),
        .alu_src_b_i      (alu_src_b_i),
        .br_src_a_i       (br_src_a_i),
        .br_src_b_i       (br_src_b_i),
        .rf_st_data_i     (rf_st_data_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .memop_type_i     (memop_type_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .memop_sign_ext_i (memop_sign_ext_i),
        .pc_i             (pc_i),
        .held_o           (held),
        .valid_ex_o       (valid_ex_o),
        .alu_res_o        (alu_res_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .rf_st_data_o     (rf_st_data_o),
        .memop_type_o     (memop_type_o),
        .memop_rd_o       (memop_rd_o),
        .memop_wr_o       (memop_wr_o),
        .memop_sign_ext_o (memop_sign_ext_o),
        .tkbr_o           (tkbr_o),
        .new_pc_o         (new_pc_o),
        .seq_new_pc_o     (seq_new_pc_o)
    );

    segre_ex_credit i_segre_ex_credit (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .item_held_i     (held),
        .credit_return_i (credit_return_i),
        .send_o          (send),
        .stall_o         (stall_o)
    );

endmodule : segre_ex_top

`default_nettype wire

// File: segre_ex_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "segre_cfg.svh"

module segre_ex_tb;

    import segre_pkg::*;

    // Limit well above the few hundred cycles the tests take
    localparam int MaxCycles = 2000;

    logic             clk_i = 1'b0;
    logic             rst_i = 1'b1;
    logic             valid_id_i = 1'b0;
    logic             inject_nops_i = 1'b0;
    logic             credit_return_i = 1'b0;
    logic             stall_o;
    alu_opcode_e      alu_opcode_i = ALU_ADD;
    word_t            alu_src_a_i = '0;
    word_t            alu_src_b_i = '0;
    word_t            br_src_a_i = '0;
    word_t            br_src_b_i = '0;
    word_t            rf_st_data_i = '0;
    logic             rf_we_i = 1'b0;
    reg_idx_t         rf_waddr_i = '0;
    memop_data_type_e memop_type_i = BYTE;
    logic             memop_rd_i = 1'b0;
    logic             memop_wr_i = 1'b0;
    logic             memop_sign_ext_i = 1'b0;
    addr_t            pc_i = '0;
    logic             valid_ex_o;
    word_t            alu_res_o;
    logic             rf_we_o;
    reg_idx_t         rf_waddr_o;
    word_t            rf_st_data_o;
    memop_data_type_e memop_type_o;
    logic             memop_rd_o;
    logic             memop_wr_o;
    logic             memop_sign_ext_o;
    logic             tkbr_o;
    addr_t            new_pc_o;
    addr_t            seq_new_pc_o;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    word_t sent_q[$];

    // Expected passthrough of the last driven item
    word_t    exp_st;
    reg_idx_t exp_waddr;
    logic     exp_we;
    logic     exp_rd;
    logic     exp_wr;
    logic     exp_sext;
    logic [1:0] exp_type;

    segre_ex_top i_segre_ex_top (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", MaxCycles);
            $display("Errors found");
            $finish;
        end
    end

    // Record every item handed to the memory stage
    always @(negedge clk_i) begin
        if (valid_ex_o) begin
            sent_q.push_back(alu_res_o);
        end
    end

    function automatic word_t model_result(alu_opcode_e op, word_t a, word_t b, addr_t pc);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_JAL, ALU_JALR: return pc + 32'd4;
            default:  return a + b;
        endcase
    endfunction

    function automatic addr_t model_target(alu_opcode_e op, word_t a, word_t b);
        if (op == ALU_JALR) begin
            return (a + b) & ~32'd1;
        end
        return a + b;
    endfunction

    function automatic logic model_taken(alu_opcode_e op, word_t a, word_t b);
        case (op)
            ALU_BEQ:  return a == b;
            ALU_BNE:  return a != b;
            ALU_BLT:  return $signed(a) < $signed(b);
            ALU_BGE:  return $signed(a) >= $signed(b);
            ALU_BLTU: return a < b;
            ALU_BGEU: return a >= b;
            ALU_JAL, ALU_JALR: return 1'b1;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Called just after a rising edge
    task automatic drive_item(alu_opcode_e op, word_t a, word_t b, word_t bra, word_t brb,
                              addr_t pc);
        exp_st    = $urandom;
        exp_waddr = reg_idx_t'($urandom);
        exp_we    = 1'($urandom);
        exp_rd    = 1'($urandom);
        exp_wr    = 1'($urandom);
        exp_sext  = 1'($urandom);
        exp_type  = 2'($urandom_range(0, 2));
        valid_id_i       <= 1'b1;
        alu_opcode_i     <= op;
        alu_src_a_i      <= a;
        alu_src_b_i      <= b;
        br_src_a_i       <= bra;
        br_src_b_i       <= brb;
        pc_i             <= pc;
        rf_st_data_i     <= exp_st;
        rf_waddr_i       <= exp_waddr;
        rf_we_i          <= exp_we;
        memop_rd_i       <= exp_rd;
        memop_wr_i       <= exp_wr;
        memop_sign_ext_i <= exp_sext;
        memop_type_i     <= memop_data_type_e'(exp_type);
    endtask

    task automatic return_credit();
        @(posedge clk_i);
        credit_return_i <= 1'b1;
        @(posedge clk_i);
        credit_return_i <= 1'b0;
    endtask

    task automatic issue_and_check(alu_opcode_e op, word_t a, word_t b, word_t bra, word_t brb);
        addr_t pc;
        int    n;
        pc = $urandom & ~32'd3;
        n  = 0;
        @(posedge clk_i);
        drive_item(op, a, b, bra, brb, pc);
        @(posedge clk_i);
        valid_id_i <= 1'b0;
        @(negedge clk_i);
        while (!valid_ex_o && n < 8) begin
            @(negedge clk_i);
            n++;
        end
        if (!valid_ex_o) begin
            errors++;
            $display("Result of opcode %s never appeared on valid_ex_o", op.name());
        end
        check_value("alu_res_o", model_result(op, a, b, pc), alu_res_o);
        // Target only means something for branches and jumps
        if (op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_JAL,
                       ALU_JALR}) begin
            check_value("new_pc_o", model_target(op, a, b), new_pc_o);
        end
        check_value("tkbr_o", model_taken(op, bra, brb), tkbr_o);
        check_value("seq_new_pc_o", pc + 32'd4, seq_new_pc_o);
        check_value("rf_st_data_o", exp_st, rf_st_data_o);
        check_value("rf_waddr_o", exp_waddr, rf_waddr_o);
        check_value("rf_we_o", exp_we, rf_we_o);
        check_value("memop_rd_o", exp_rd, memop_rd_o);
        check_value("memop_wr_o", exp_wr, memop_wr_o);
        check_value("memop_sign_ext_o", exp_sext, memop_sign_ext_o);
        check_value("memop_type_o", exp_type, memop_type_o);
        return_credit();
    endtask

    task automatic test_reset();
        @(negedge clk_i);
        check_value("valid_ex_o", 0, valid_ex_o);
        check_value("stall_o", 0, stall_o);
        check_value("tkbr_o", 0, tkbr_o);
        check_value("rf_we_o", 0, rf_we_o);
        check_value("memop_rd_o", 0, memop_rd_o);
        check_value("memop_wr_o", 0, memop_wr_o);
    endtask

    task automatic test_alu_ops();
        for (int i = 0; i < 40; i++) begin
            issue_and_check(alu_opcode_e'(i % 10), $urandom, $urandom, $urandom, $urandom);
        end
    endtask

    task automatic test_branches();
        word_t a;
        word_t b;
        for (int i = 0; i < 24; i++) begin
            a = $urandom;
            b = ($urandom_range(0, 3) == 0) ? a : $urandom;
            issue_and_check(alu_opcode_e'(10 + i % 8), $urandom, $urandom, a, b);
        end
    endtask

    task automatic test_credit_backpressure();
        sent_q.delete();
        fork
            begin
                for (int i = 0; i < `EX_CREDITS + 3; i++) begin
                    @(posedge clk_i);
                    drive_item(ALU_ADD, 32'h100 + i, 32'd0, 32'd0, 32'd0, 32'd0);
                    do @(negedge clk_i); while (stall_o);
                end
                @(posedge clk_i);
                valid_id_i <= 1'b0;
            end
            begin
                repeat (10) @(negedge clk_i);
                check_value("sent items", `EX_CREDITS, sent_q.size());
                check_value("stall_o", 1, stall_o);
                for (int k = 1; k <= 3; k++) begin
                    return_credit();
                    repeat (3) @(negedge clk_i);
                    check_value("sent items", `EX_CREDITS + k, sent_q.size());
                end
            end
        join
        for (int i = 0; i < sent_q.size(); i++) begin
            check_value("alu_res_o order", 32'h100 + i, sent_q[i]);
        end
        repeat (`EX_CREDITS) return_credit();
    endtask

    task automatic test_flush();
        sent_q.delete();
        for (int i = 0; i <= `EX_CREDITS; i++) begin
            @(posedge clk_i);
            drive_item(ALU_ADD, 32'h200 + i, 32'd0, 32'd0, 32'd0, 32'd0);
        end
        @(posedge clk_i);
        valid_id_i    <= 1'b0;
        inject_nops_i <= 1'b1;
        @(negedge clk_i);
        check_value("stall_o", 1, stall_o);
        @(posedge clk_i);
        inject_nops_i <= 1'b0;
        @(negedge clk_i);
        check_value("stall_o", 0, stall_o);
        // Flushed item must not leave once credits return
        repeat (`EX_CREDITS) return_credit();
        repeat (2) @(negedge clk_i);
        check_value("sent items", `EX_CREDITS, sent_q.size());
        issue_and_check(ALU_SUB, $urandom, $urandom, 32'd0, 32'd0);
    endtask

    task automatic report(string name, int errors_before);
        $display("%s finished with %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int e;
        void'($urandom(88690));
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        e = errors;
        test_reset();
        report("test_reset", e);
        e = errors;
        test_alu_ops();
        report("test_alu_ops", e);
        e = errors;
        test_branches();
        report("test_branches", e);
        e = errors;
        test_credit_backpressure();
        report("test_credit_backpressure", e);
        e = errors;
        test_flush();
        report("test_flush", e);
        $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : segre_ex_tb

`default_nettype wire

// File: tb.f
+incdir+.
segre_pkg.sv
segre_alu.sv
segre_tkbr.sv
segre_ex_stage.sv
segre_ex_credit.sv
segre_ex_top.sv
segre_ex_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= segre_ex_tb
RTL_TOP   ?= segre_ex_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) segre_cfg.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q '^No errors$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
